// File: hw/cache_geom_pkg.sv
// icache geometry package
// fixed size of the L1 instruction cache and the vector types built from it

package cache_geom_pkg;

   // ----------------------------------------------------------------------
   // address split
   //    | tag (25) | set (3) | offset (4) |
   // ----------------------------------------------------------------------
   localparam int ADDR_W     = 32;                  // byte address
   localparam int LINE_BYTES = 16;                  // bytes per cache line
   localparam int OFFS_W     = 4;                   // byte offset in a line
   localparam int NUM_SETS   = 8;
   localparam int SET_W      = 3;                   // set index bits
   localparam int NUM_WAYS   = 4;
   localparam int WAY_W      = 2;                   // way index bits
   localparam int TAG_W      = ADDR_W - SET_W - OFFS_W;   // 25 bits left over
   localparam int LINE_W     = LINE_BYTES * 8;      // 128 bit line

   // ----------------------------------------------------------------------
   // vector types
   // ----------------------------------------------------------------------
   typedef logic [ADDR_W-1:0]        addr_t;        // full byte address
   typedef logic [TAG_W-1:0]         tag_t;
   typedef logic [SET_W-1:0]         set_t;
   typedef logic [WAY_W-1:0]         way_t;
   typedef logic [LINE_W-1:0]        line_t;        // one whole cache line

   // line address sent to the arbiter, tag on top of set
   typedef logic [TAG_W+SET_W-1:0]   line_addr_t;

   // one flag per way, e.g. the valid bits of a set
   typedef logic [NUM_WAYS-1:0]      way_mask_t;

endpackage

// File: hw/cache_ctrl_pkg.sv
// icache control package
// controller states and the LRU rank type

package cache_ctrl_pkg;

   // main controller states
   typedef enum logic [2:0] {
      IC_IDLE,                                      // wait for fetch or invalidate
      IC_MISS_REQ,                                  // line request to arbiter
      IC_MISS_FILL,                                 // wait for line from arbiter
      IC_MISS_RESP,                                 // hand filled line to fetch
      IC_INVAL                                      // single line invalidate
   } ic_state_t;

   // position of a way in the recency order of its set
   typedef logic [1:0] lru_rank_t;

   localparam lru_rank_t RANK_LRU = 2'd0;           // least recently used
   localparam lru_rank_t RANK_MRU = 2'd3;           // most recently used

endpackage

// File: hw/icache_store.sv
// icache storage
// line, tag and valid arrays, all in flops, read out for the current set

`timescale 1ns/1ps

module icache_store
   import cache_geom_pkg::*;
(
   input  logic                      clk_in,
   input  logic                      reset_in,

   input  set_t                      cur_set,       // working set
   input  tag_t                      cur_tag,       // tag written on fill
   input  way_t                      sel_way,       // way picked by lookup

   input  logic                      fill_en,       // write line from arbiter
   input  line_t                     fill_line,
   input  logic                      inval_en,      // drop the selected line
   input  logic                      flush_clr,     // clear every valid bit

   output way_mask_t                 valid_row,
   output tag_t [NUM_WAYS-1:0]       tag_row,
   output line_t                     rd_line
);

   // ----------------------------------------------------------------------
   // storage
   // ----------------------------------------------------------------------
   line_t      line_mem  [NUM_SETS][NUM_WAYS];      // payload, no reset
   tag_t       tag_mem   [NUM_SETS][NUM_WAYS];
   way_mask_t  valid_mem [NUM_SETS];                // one bit per way per set

   // valid bits
   always_ff @(posedge clk_in)
   begin
      if (reset_in || flush_clr)
      begin
         for (int s = 0; s < NUM_SETS; s++)
            valid_mem[s] <= '0;                     // whole cache empty
      end
      else if (fill_en)
         valid_mem[cur_set][sel_way] <= 1'b1;       // line arrived
      else if (inval_en)
         valid_mem[cur_set][sel_way] <= 1'b0;       // d-cache asked to drop it
   end

   // line and tag written together on a fill
   always_ff @(posedge clk_in)
   begin
      if (fill_en)
      begin
         line_mem[cur_set][sel_way] <= fill_line;
         tag_mem[cur_set][sel_way]  <= cur_tag;
      end
   end

   // ----------------------------------------------------------------------
   // read side
   // ----------------------------------------------------------------------
   assign valid_row = valid_mem[cur_set];
   assign rd_line   = line_mem[cur_set][sel_way];   // hit way once a hit is seen

   always_comb
   begin
      for (int w = 0; w < NUM_WAYS; w++)
         tag_row[w] = tag_mem[cur_set][w];
   end

   // controller only fills in IC_MISS_FILL and only invalidates in IC_INVAL
   a_no_fill_and_inval : assert property (
      @(posedge clk_in) disable iff (reset_in)
      !(fill_en && inval_en)
   ) else $error("fill and invalidate strobes together");

endmodule

// File: hw/icache_lookup.sv
// icache lookup
// tag compare, empty way search and way choice for the current set

`timescale 1ns/1ps

module icache_lookup
   import cache_geom_pkg::*;
(
   input  way_mask_t                 valid_row,     // valid bits of the set
   input  tag_t [NUM_WAYS-1:0]       tag_row,       // stored tags of the set
   input  tag_t                      cur_tag,       // tag being looked up
   input  way_t                      lru_way,       // rank 0 way from the LRU

   output logic                      hit,
   output way_t                      sel_way
);

   way_t  hit_way;                                  // matching way
   logic  empty_found;                              // some way still unused
   way_t  empty_way;

   // ----------------------------------------------------------------------
   // hit detect, last match in the loop wins
   // ----------------------------------------------------------------------
   always_comb
   begin
      hit     = 1'b0;
      hit_way = '0;                                 // don't care without a hit
      for (int w = 0; w < NUM_WAYS; w++)
      begin
         if (valid_row[w] && (tag_row[w] == cur_tag))
         begin
            hit     = 1'b1;
            hit_way = way_t'(w);
         end
      end
   end

   // empty way search, highest free way taken
   always_comb
   begin
      empty_found = 1'b0;
      empty_way   = '0;
      for (int w = 0; w < NUM_WAYS; w++)
      begin
         if (!valid_row[w])
         begin
            empty_found = 1'b1;
            empty_way   = way_t'(w);
         end
      end
   end

   // hit way first, then a free way, then evict the LRU way
   assign sel_way = hit         ? hit_way   :
                    empty_found ? empty_way :
                                  lru_way;

endmodule

// File: hw/icache_lru.sv
// icache LRU
// ranked recency order per set, victim search and update on each access

`timescale 1ns/1ps

module icache_lru
   import cache_geom_pkg::*;
   import cache_ctrl_pkg::*;
(
   input  logic       clk_in,
   input  logic       reset_in,

   input  set_t       cur_set,                      // working set
   input  way_t       sel_way,                      // way being accessed
   input  logic       touch,                        // access returned a line

   output way_t       lru_way                       // way holding rank 0
);

   lru_rank_t  rank_mem [NUM_SETS][NUM_WAYS];       // rank of each way in each set
   lru_rank_t  next_rank [NUM_WAYS];                // ranks of cur_set after touch
   lru_rank_t  old_rank;                            // rank of sel_way before touch
   way_mask_t  rank_seen;                           // which ranks occur in cur_set

   // ----------------------------------------------------------------------
   // rank update
   // ----------------------------------------------------------------------
   assign old_rank = rank_mem[cur_set][sel_way];

   always_comb
   begin
      for (int w = 0; w < NUM_WAYS; w++)
      begin
         if (way_t'(w) == sel_way)
            next_rank[w] = RANK_MRU;                // touched way goes to the top
         else if (rank_mem[cur_set][w] > old_rank)
            next_rank[w] = rank_mem[cur_set][w] - 1'b1;   // slides down one
         else
            next_rank[w] = rank_mem[cur_set][w];    // older ways keep their place
      end
   end

   always_ff @(posedge clk_in)
   begin
      if (reset_in)
      begin
         for (int s = 0; s < NUM_SETS; s++)
            for (int w = 0; w < NUM_WAYS; w++)
               rank_mem[s][w] <= lru_rank_t'(w);    // way n starts at rank n
      end
      else if (touch)
      begin
         for (int w = 0; w < NUM_WAYS; w++)
            rank_mem[cur_set][w] <= next_rank[w];
      end
   end

   // ----------------------------------------------------------------------
   // victim search
   // ----------------------------------------------------------------------
   always_comb
   begin
      lru_way   = '0;
      rank_seen = '0;
      for (int w = 0; w < NUM_WAYS; w++)
      begin
         rank_seen[rank_mem[cur_set][w]] = 1'b1;
         if (rank_mem[cur_set][w] == RANK_LRU)
            lru_way = way_t'(w);
      end
   end

   // ranks form a permutation, so every rank shows up once
   a_ranks_distinct : assert property (
      @(posedge clk_in) disable iff (reset_in)
      rank_seen == '1
   ) else $error("duplicate LRU rank in set %0d", cur_set);

endmodule

// File: hw/icache_ctrl.sv
// icache controller
// FSM for hit, miss, invalidate and flush, working address select and strobes

`timescale 1ns/1ps

module icache_ctrl
   import cache_geom_pkg::*;
   import cache_ctrl_pkg::*;
(
   input  logic        clk_in,
   input  logic        reset_in,

   // fetch side
   input  addr_t       ic_addr,
   input  logic        ic_req,
   input  logic        ic_flush,                    // one cycle pulse
   output logic        ic_ack,

   // invalidate from d-cache
   input  logic        inv_req,
   input  addr_t       inv_addr,
   output logic        inv_ack,

   // lookup result
   input  logic        hit,

   // arbiter channels
   output line_addr_t  arb_req_addr,
   output logic        arb_req_valid,
   input  logic        arb_req_rdy,
   input  logic        arb_ack_valid,
   output logic        arb_ack_rdy,

   // to store and LRU
   output set_t        cur_set,
   output tag_t        cur_tag,
   output logic        fill_en,
   output logic        inval_en,
   output logic        flush_clr,
   output logic        touch
);

   ic_state_t  state;
   ic_state_t  next_state;
   logic       flush_pend;                          // flush seen, not yet done
   addr_t      work_addr;                           // address in use this cycle

   // ----------------------------------------------------------------------
   // working address
   // ----------------------------------------------------------------------
   assign work_addr    = (state == IC_INVAL) ? inv_addr : ic_addr;
   assign cur_set      = work_addr[OFFS_W +: SET_W];
   assign cur_tag      = work_addr[OFFS_W+SET_W +: TAG_W];
   assign arb_req_addr = {cur_tag, cur_set};        // fetch side holds ic_addr during a miss

   // ----------------------------------------------------------------------
   // state and flush flag
   // ----------------------------------------------------------------------
   assign flush_clr = (state == IC_IDLE) && flush_pend;   // only when nothing is open

   always_ff @(posedge clk_in)
   begin
      if (reset_in)
         state <= IC_IDLE;
      else
         state <= next_state;
   end

   always_ff @(posedge clk_in)
   begin
      if (reset_in || flush_clr)
         flush_pend <= 1'b0;
      else if (ic_flush)
         flush_pend <= 1'b1;                        // hold the pulse until idle
   end

   // ----------------------------------------------------------------------
   // next state and strobes
   // ----------------------------------------------------------------------
   always_comb
   begin
      next_state    = state;
      ic_ack        = 1'b0;
      inv_ack       = 1'b0;
      arb_req_valid = 1'b0;
      arb_ack_rdy   = 1'b0;
      fill_en       = 1'b0;
      inval_en      = 1'b0;

      case (state)
         IC_IDLE:
         begin
            if (inv_req)                            // invalidate wins over fetch
               next_state = IC_INVAL;
            else if (ic_req)
            begin
               if (hit)
                  ic_ack = 1'b1;                    // line goes out this cycle
               else
                  next_state = IC_MISS_REQ;
            end
         end

         IC_MISS_REQ:
         begin
            arb_req_valid = 1'b1;
            if (arb_req_rdy)
               next_state = IC_MISS_FILL;           // request taken
         end

         IC_MISS_FILL:
         begin
            arb_ack_rdy = 1'b1;
            if (arb_ack_valid)
            begin
               fill_en    = 1'b1;                   // write line, tag, valid
               next_state = IC_MISS_RESP;
            end
         end

         IC_MISS_RESP:
         begin
            ic_ack     = 1'b1;                      // filled line now hits
            next_state = IC_IDLE;
         end

         IC_INVAL:
         begin
            inv_ack    = 1'b1;
            inval_en   = hit;                       // absent line, nothing to do
            next_state = IC_IDLE;
         end

         default:
            next_state = IC_IDLE;
      endcase
   end

   assign touch = ic_ack;                           // every returned line updates LRU

   // request stays up and steady until the arbiter takes it
   a_req_held : assert property (
      @(posedge clk_in) disable iff (reset_in)
      arb_req_valid && !arb_req_rdy |=> arb_req_valid && $stable(arb_req_addr)
   ) else $error("arbiter request dropped or changed before transfer");

endmodule

// File: hw/icache_top.sv
// L1 instruction cache top
// 4-way, 8 sets of 16 byte lines, between fetch stage and memory arbiter

`timescale 1ns/1ps

module icache_top
   import cache_geom_pkg::*;
(
   input  logic        clk_in,
   input  logic        reset_in,

   // fetch stage
   input  addr_t       ic_addr,
   input  logic        ic_req,
   output logic        ic_ack,
   output line_t       ic_rd_data,
   input  logic        ic_flush,

   // arbiter request channel
   output line_addr_t  arb_req_addr,
   output logic        arb_req_valid,
   input  logic        arb_req_rdy,

   // arbiter response channel
   input  line_t       arb_ack_data,
   input  logic        arb_ack_valid,
   output logic        arb_ack_rdy,

   // invalidate from d-cache
   input  logic        inv_req,
   input  addr_t       inv_addr,
   output logic        inv_ack
);

   // ----------------------------------------------------------------------
   // internal wires
   // ----------------------------------------------------------------------
   set_t                 cur_set;
   tag_t                 cur_tag;
   way_mask_t            valid_row;
   tag_t [NUM_WAYS-1:0]  tag_row;
   way_t                 lru_way;
   way_t                 sel_way;
   logic                 hit;
   logic                 fill_en;
   logic                 inval_en;
   logic                 flush_clr;
   logic                 touch;

   icache_ctrl u_ctrl (
      .clk_in, .reset_in,
      .ic_addr, .ic_req, .ic_flush, .ic_ack,
      .inv_req, .inv_addr, .inv_ack,
      .hit,
      .arb_req_addr, .arb_req_valid, .arb_req_rdy, .arb_ack_valid, .arb_ack_rdy,
      .cur_set, .cur_tag, .fill_en, .inval_en, .flush_clr, .touch
   );

   icache_store u_store (
      .clk_in, .reset_in,
      .cur_set, .cur_tag, .sel_way,
      .fill_en, .fill_line (arb_ack_data), .inval_en, .flush_clr,
      .valid_row, .tag_row,
      .rd_line   (ic_rd_data)                       // selected way goes straight to fetch
   );

   icache_lookup u_lookup (
      .valid_row, .tag_row, .cur_tag, .lru_way,
      .hit, .sel_way
   );

   icache_lru u_lru (
      .clk_in, .reset_in,
      .cur_set, .sel_way, .touch,
      .lru_way
   );

endmodule

// File: bench/tb_icache.sv
// icache testbench
// random fetch, invalidate and flush traffic checked against a reference model

`timescale 1ns/1ps

module tb_icache
   import cache_geom_pkg::*;
();

   localparam int CLK_PERIOD    = 40;
   localparam int NUM_OPS       = 400;
   localparam int CYCLES_PER_OP = 20;
   localparam int NUM_LINES     = 24;               // 8 tags in each of 3 sets

   logic        clk_in = 1'b0;
   logic        reset_in;
   addr_t       ic_addr;
   logic        ic_req;
   logic        ic_ack;
   line_t       ic_rd_data;
   logic        ic_flush;
   line_addr_t  arb_req_addr;
   logic        arb_req_valid;
   logic        arb_req_rdy;
   line_t       arb_ack_data;
   logic        arb_ack_valid;
   logic        arb_ack_rdy;
   logic        inv_req;
   addr_t       inv_addr;
   logic        inv_ack;

   logic [31:0] lfsr = 32'hfe37;

   // reference model state
   logic        m_valid [NUM_SETS][NUM_WAYS];
   tag_t        m_tag   [NUM_SETS][NUM_WAYS];
   int          m_rank  [NUM_SETS][NUM_WAYS];       // 0 least recent, 3 most recent

   icache_top UUT (
      .clk_in, .reset_in,
      .ic_addr, .ic_req, .ic_ack, .ic_rd_data, .ic_flush,
      .arb_req_addr, .arb_req_valid, .arb_req_rdy,
      .arb_ack_data, .arb_ack_valid, .arb_ack_rdy,
      .inv_req, .inv_addr, .inv_ack
   );

   always #(CLK_PERIOD/2) clk_in = ~clk_in;

   // ----------------------------------------------------------------------
   // random numbers and address rules
   // ----------------------------------------------------------------------
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};                 // one step per bit
      end
      return v;
   endfunction

   function automatic line_addr_t line_addr_of(input int idx);
      tag_t t;
      set_t s;
      t = tag_t'((idx / 3) * 32'h0001_2345 + 32'h0000_0abc);
      s = set_t'((idx % 3) * 3);                    // sets 0, 3 and 6
      return {t, s};
   endfunction

   // word k of the line is the line address xor k
   function automatic line_t line_data_of(input line_addr_t la);
      line_t d;
      for (int k = 0; k < 4; k++)
         d[32*k +: 32] = 32'(la) ^ 32'(k);
      return d;
   endfunction

   task automatic expect_eq(input string name, input line_t got, input line_t exp);
      if (got !== exp)
      begin
         $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // ----------------------------------------------------------------------
   // reference model
   // ----------------------------------------------------------------------
   task automatic model_find(input line_addr_t la, output logic found, output way_t way);
      set_t s;
      tag_t t;
      logic empty;
      way_t empty_way;
      s         = la[SET_W-1:0];
      t         = la[SET_W +: TAG_W];
      found     = 1'b0;
      way       = '0;
      empty     = 1'b0;
      empty_way = '0;
      for (int w = 0; w < NUM_WAYS; w++)
      begin
         if (m_valid[s][w] && m_tag[s][w] == t)
         begin
            found = 1'b1;
            way   = way_t'(w);
         end
         if (!m_valid[s][w])
         begin
            empty     = 1'b1;
            empty_way = way_t'(w);                  // highest free way
         end
      end
      if (!found && empty)
         way = empty_way;
      else if (!found)
      begin
         for (int w = 0; w < NUM_WAYS; w++)
            if (m_rank[s][w] == 0)
               way = way_t'(w);                     // evict least recent
      end
   endtask

   task automatic model_touch(input set_t s, input way_t way);
      int old;
      old = m_rank[s][way];
      for (int w = 0; w < NUM_WAYS; w++)
      begin
         if (way_t'(w) == way)
            m_rank[s][w] = 3;
         else if (m_rank[s][w] > old)
            m_rank[s][w]--;
      end
   endtask

   // ----------------------------------------------------------------------
   // operations
   // ----------------------------------------------------------------------
   task automatic fetch_line(input int idx);
      line_addr_t la;
      line_addr_t req_seen;
      logic       exp_hit;
      way_t       way;
      int         gap;
      la = line_addr_of(idx);
      model_find(la, exp_hit, way);
      @(posedge clk_in);
      ic_req  <= 1'b1;
      ic_addr <= {la, 4'(rand_bits(4))};            // any byte of the line
      @(negedge clk_in);
      expect_eq("ic_ack", ic_ack, exp_hit);
      expect_eq("arb_req_valid", arb_req_valid, 1'b0);
      if (!exp_hit)
      begin
         gap = rand_bits(2);
         repeat (gap + 1)
         begin
            @(negedge clk_in);
            expect_eq("arb_req_valid", arb_req_valid, 1'b1);
            expect_eq("arb_req_addr", arb_req_addr, la);   // steady under back-pressure
         end
         @(posedge clk_in);
         arb_req_rdy <= 1'b1;
         @(negedge clk_in);
         expect_eq("arb_req_valid", arb_req_valid, 1'b1);
         req_seen = arb_req_addr;
         @(posedge clk_in);
         arb_req_rdy <= 1'b0;                       // request taken here
         gap = rand_bits(2);
         repeat (gap + 1)
         begin
            @(negedge clk_in);
            expect_eq("arb_ack_rdy", arb_ack_rdy, 1'b1);
            expect_eq("ic_ack", ic_ack, 1'b0);
         end
         @(posedge clk_in);
         arb_ack_valid <= 1'b1;
         arb_ack_data  <= line_data_of(req_seen);
         @(posedge clk_in);
         arb_ack_valid <= 1'b0;                     // line handed over
         @(negedge clk_in);
         expect_eq("ic_ack", ic_ack, 1'b1);
         m_valid[la[SET_W-1:0]][way] = 1'b1;
         m_tag[la[SET_W-1:0]][way]   = la[SET_W +: TAG_W];
      end
      expect_eq("ic_rd_data", ic_rd_data, line_data_of(la));
      model_touch(la[SET_W-1:0], way);
      @(posedge clk_in);
      ic_req <= 1'b0;
      @(negedge clk_in);
      expect_eq("ic_ack", ic_ack, 1'b0);            // one acknowledge only
   endtask

   task automatic invalidate_line(input int idx);
      line_addr_t la;
      logic       exp_hit;
      way_t       way;
      la = line_addr_of(idx);
      model_find(la, exp_hit, way);
      @(posedge clk_in);
      inv_req  <= 1'b1;
      inv_addr <= {la, 4'(rand_bits(4))};
      @(negedge clk_in);
      expect_eq("inv_ack", inv_ack, 1'b0);
      @(negedge clk_in);
      expect_eq("inv_ack", inv_ack, 1'b1);          // one cycle after sampling
      @(posedge clk_in);
      inv_req <= 1'b0;
      @(negedge clk_in);
      expect_eq("inv_ack", inv_ack, 1'b0);
      if (exp_hit)
         m_valid[la[SET_W-1:0]][way] = 1'b0;
   endtask

   task automatic flush_cache();
      @(posedge clk_in);
      ic_flush <= 1'b1;
      @(posedge clk_in);
      ic_flush <= 1'b0;
      repeat (2) @(posedge clk_in);                 // quiet while the flush drains
      for (int s = 0; s < NUM_SETS; s++)
         for (int w = 0; w < NUM_WAYS; w++)
            m_valid[s][w] = 1'b0;
   endtask

   task automatic check_quiet();
      @(negedge clk_in);
      expect_eq("ic_ack", ic_ack, 1'b0);
      expect_eq("inv_ack", inv_ack, 1'b0);
      expect_eq("arb_req_valid", arb_req_valid, 1'b0);
      expect_eq("arb_ack_rdy", arb_ack_rdy, 1'b0);
   endtask

   // ----------------------------------------------------------------------
   // main sequence and watchdog
   // ----------------------------------------------------------------------
   initial
   begin
      int kind;
      int idx;
      reset_in      = 1'b1;
      ic_addr       = '0;
      ic_req        = 1'b0;
      ic_flush      = 1'b0;
      arb_req_rdy   = 1'b0;
      arb_ack_data  = '0;
      arb_ack_valid = 1'b0;
      inv_req       = 1'b0;
      inv_addr      = '0;
      for (int s = 0; s < NUM_SETS; s++)
         for (int w = 0; w < NUM_WAYS; w++)
         begin
            m_valid[s][w] = 1'b0;
            m_rank[s][w]  = w;                      // reset order of the ranks
         end
      repeat (5) @(posedge clk_in);
      reset_in <= 1'b0;
      check_quiet();
      for (int op = 0; op < NUM_OPS; op++)
      begin
         kind = rand_bits(4);
         idx  = rand_bits(5) % NUM_LINES;
         if (kind == 0)
            flush_cache();
         else if (kind < 5)
         begin
            invalidate_line(idx);
            if (rand_bits(1) == 1)
               fetch_line(idx);                     // refetch the dropped line
         end
         else
            fetch_line(idx);
         check_quiet();
      end
      $display("TESTBENCH PASSED");
      $finish;
   end

   initial
   begin
      #((NUM_OPS * CYCLES_PER_OP + 10) * CLK_PERIOD);
      $display("timeout at %0t, the operations did not finish", $time);
      $display("TESTBENCH FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

// File: tb.f
hw/cache_geom_pkg.sv
hw/cache_ctrl_pkg.sv
hw/icache_store.sv
hw/icache_lookup.sv
hw/icache_lru.sv
hw/icache_ctrl.sv
hw/icache_top.sv
bench/tb_icache.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_icache -o sim_icache

# a failing run exits nonzero, the printed result decides
sim_out=$(./obj_dir/sim_icache || true)
echo "$sim_out"

if grep -q "TESTBENCH PASSED" <<< "$sim_out"; then
   exit 0
else
   exit 1
fi
